/* rtl/vctr_pkg.sv */
`default_nettype none

package vctr_pkg;

  // Controller states of the job FSM
  typedef enum logic [1:0] {
    ST_IDLE      = 2'd0,  // Waiting for start
    ST_READING   = 2'd1,  // Loading operand vectors A then B
    ST_OPERATION = 2'd2,  // Issuing element pairs to the ALU
    ST_DONE      = 2'd3   // Results available for draining
  } vctr_state_t;

  // Element-wise operation selected at start
  // All arithmetic wraps modulo 2**DATA_WIDTH
  typedef enum logic [1:0] {
    OP_ADD = 2'd0,  // A + B
    OP_SUB = 2'd1,  // A - B
    OP_AND = 2'd2,  // A & B
    OP_XOR = 2'd3   // A ^ B
  } vctr_op_t;

endpackage

`default_nettype wire

/* rtl/hsid_fifo.sv */
`default_nettype none

module hsid_fifo #(
  parameter int DATA_WIDTH = 16,
  parameter int FIFO_DEPTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  wr_en,
  input  logic                  rd_en,
  input  logic [DATA_WIDTH-1:0] data_in,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  full,
  output logic                  empty
);

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(FIFO_DEPTH - 1);
  localparam logic [CNT_W-1:0] FULL_CNT = CNT_W'(FIFO_DEPTH);

  logic [DATA_WIDTH-1:0] mem [FIFO_DEPTH];
  logic [PTR_W-1:0]      wr_ptr;
  logic [PTR_W-1:0]      rd_ptr;
  logic [CNT_W-1:0]      count;  // Occupancy, 0 to FIFO_DEPTH
  logic                  do_wr;
  logic                  do_rd;

  assign do_wr = wr_en && !full;  // Write while full is dropped
  assign do_rd = rd_en && !empty; // Read while empty is ignored

  assign full     = (count == FULL_CNT);
  assign empty    = (count == '0);
  assign data_out = mem[rd_ptr];  // Show-ahead head word

  always_ff @(posedge clk) begin
    if (do_wr) begin
      mem[wr_ptr] <= data_in;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + PTR_W'(1);  // Wrap for any depth
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + PTR_W'(1);
      end
      case ({do_wr, do_rd})
        2'b10:   count <= count + CNT_W'(1);
        2'b01:   count <= count - CNT_W'(1);
        default: count <= count;  // Idle or simultaneous push and pop
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/vctr_alu.sv */
`default_nettype none

module vctr_alu
  import vctr_pkg::*;
#(
  parameter int DATA_WIDTH = 16
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  issue,
  input  vctr_op_t              op,
  input  logic [DATA_WIDTH-1:0] a,
  input  logic [DATA_WIDTH-1:0] b,
  output logic [DATA_WIDTH-1:0] result,
  output logic                  result_valid
);

  logic [DATA_WIDTH-1:0] alu_out;

  // Sums and differences drop the carry, so results wrap
  always_comb begin
    case (op)
      OP_ADD:  alu_out = a + b;
      OP_SUB:  alu_out = a - b;
      OP_AND:  alu_out = a & b;
      OP_XOR:  alu_out = a ^ b;
      default: alu_out = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      result <= alu_out;  // Hold last result between issues
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= issue;  // One cycle latency
    end
  end

endmodule

`default_nettype wire

/* rtl/vctr_fifo_full.sv */
`default_nettype none

module vctr_fifo_full
  import vctr_pkg::*;
#(
  parameter int DATA_WIDTH    = 16,
  parameter int VECTOR_LENGTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  vctr_op_t              op,
  input  logic                  data_in_en,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  data_out_en,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  done,
  output logic                  idle,
  output logic                  ready
);

  vctr_state_t state;
  vctr_state_t next_state;
  vctr_op_t    op_q;  // Opcode of the running job

  logic                  a_full, a_empty;
  logic                  b_full, b_empty;
  logic                  r_full, r_empty;
  logic [DATA_WIDTH-1:0] a_data, b_data;
  logic                  wr_a, wr_b;
  logic                  issue;
  logic                  rd_r;
  logic [DATA_WIDTH-1:0] alu_result;
  logic                  alu_valid;

  assign idle  = (state == ST_IDLE);
  assign ready = (state == ST_READING);
  assign done  = (state == ST_DONE);

  // First vector fills A, second fills B, anything else is dropped
  assign wr_a = ready && data_in_en && !a_full;
  assign wr_b = ready && data_in_en && a_full && !b_full;

  // One element pair per cycle, both operand FIFOs popped together
  assign issue = (state == ST_OPERATION) && !a_empty && !b_empty && !r_full;

  assign rd_r = done && data_out_en;

  always_comb begin
    next_state = state;
    case (state)
      ST_IDLE:      if (start) next_state = ST_READING;
      ST_READING:   if (b_full) next_state = ST_OPERATION;
      ST_OPERATION: if (r_full && a_empty && b_empty) next_state = ST_DONE;
      ST_DONE:      if (r_empty) next_state = ST_IDLE;
      default:      next_state = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= ST_IDLE;
      op_q  <= OP_ADD;
    end else begin
      state <= next_state;
      if (idle && start) begin
        op_q <= op;  // Latched on the start edge
      end
    end
  end

  hsid_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .FIFO_DEPTH(VECTOR_LENGTH)
  ) fifo_a_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_a),
    .rd_en   (issue),
    .data_in (data_in),
    .data_out(a_data),
    .full    (a_full),
    .empty   (a_empty)
  );

  hsid_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .FIFO_DEPTH(VECTOR_LENGTH)
  ) fifo_b_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (wr_b),
    .rd_en   (issue),
    .data_in (data_in),
    .data_out(b_data),
    .full    (b_full),
    .empty   (b_empty)
  );

  vctr_alu #(
    .DATA_WIDTH(DATA_WIDTH)
  ) alu_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue       (issue),
    .op          (op_q),
    .a           (a_data),
    .b           (b_data),
    .result      (alu_result),
    .result_valid(alu_valid)
  );

  hsid_fifo #(
    .DATA_WIDTH(DATA_WIDTH),
    .FIFO_DEPTH(VECTOR_LENGTH)
  ) fifo_r_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .wr_en   (alu_valid),  // Every ALU result lands here
    .rd_en   (rd_r),
    .data_in (alu_result),
    .data_out(data_out),
    .full    (r_full),
    .empty   (r_empty)
  );

endmodule

`default_nettype wire

/* rtl/vctr_unit_top.sv */
`default_nettype none

module vctr_unit_top
  import vctr_pkg::*;
#(
  parameter int DATA_WIDTH    = 16,
  parameter int VECTOR_LENGTH = 8
) (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  input  vctr_op_t              op,
  input  logic                  data_in_en,
  input  logic [DATA_WIDTH-1:0] data_in,
  input  logic                  data_out_en,
  output logic [DATA_WIDTH-1:0] data_out,
  output logic                  done,
  output logic                  idle,
  output logic                  ready
);

  vctr_fifo_full #(
    .DATA_WIDTH   (DATA_WIDTH),
    .VECTOR_LENGTH(VECTOR_LENGTH)
  ) vctr_fifo_full_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .op         (op),
    .data_in_en (data_in_en),
    .data_in    (data_in),
    .data_out_en(data_out_en),
    .data_out   (data_out),
    .done       (done),
    .idle       (idle),
    .ready      (ready)
  );

endmodule

`default_nettype wire

/* tests/tb_vctr_unit.sv */
`default_nettype none

module tb_vctr_unit
  import vctr_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int DW = 16;
  localparam int VL = 8;
  localparam int MAX_CYCLES = 3000;  // Nine jobs of about 4*VL+20 cycles fit with wide margin
  localparam int DONE_LIMIT = 4 * VL + 20;

  logic          clk;
  logic          rst_n;
  logic          start;
  vctr_op_t      op;
  logic          data_in_en;
  logic [DW-1:0] data_in;
  logic          data_out_en;
  logic [DW-1:0] data_out;
  logic          done;
  logic          idle;
  logic          ready;

  logic [DW-1:0] vec_a    [VL];
  logic [DW-1:0] vec_b    [VL];
  logic [DW-1:0] expected [VL];
  int            errors = 0;
  int            cycle_count = 0;
  int            seed = 32'h8c5c4407;

  vctr_unit_top #(
    .DATA_WIDTH   (DW),
    .VECTOR_LENGTH(VL)
  ) vctr_unit_top_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .op         (op),
    .data_in_en (data_in_en),
    .data_in    (data_in),
    .data_out_en(data_out_en),
    .data_out   (data_out),
    .done       (done),
    .idle       (idle),
    .ready      (ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin : watchdog
    while (cycle_count < MAX_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
    errors++;
    $display("Summary: %0d errors", errors);
    $display("TEST FAILED");
    $finish;
  end

  // Reference model for one result element
  function automatic logic [DW-1:0] expect_elem(vctr_op_t o, logic [DW-1:0] a,
                                                logic [DW-1:0] b);
    int s;
    case (o)
      OP_ADD: begin
        s = int'(a) + int'(b);
        return s[DW-1:0];  // Carry out dropped
      end
      OP_SUB: begin
        s = int'(a) - int'(b);
        return s[DW-1:0];  // Borrow wraps
      end
      OP_AND:  return a & b;
      OP_XOR:  return a ^ b;
      default: return '0;
    endcase
  endfunction

  task automatic tick();
    @(posedge clk);
    #2;  // Drive and sample just after the edge
  endtask

  task automatic check_value(input string name, input logic [DW-1:0] exp,
                             input logic [DW-1:0] act);
    assert (act === exp) else begin
      $display("MISMATCH %s expected %h actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic check_flag(input logic cond, input string msg);
    assert (cond === 1'b1) else begin
      $display("ERROR: %s", msg);
      errors++;
    end
  endtask

  task automatic fill_random();
    for (int i = 0; i < VL; i++) begin
      vec_a[i] = DW'($random(seed));
      vec_b[i] = DW'($random(seed));
    end
  endtask

  task automatic compute_expected(input vctr_op_t o);
    for (int i = 0; i < VL; i++) begin
      expected[i] = expect_elem(o, vec_a[i], vec_b[i]);
    end
  endtask

  task automatic start_job(input vctr_op_t o);
    int n;
    n = 0;
    while (!idle && n < DONE_LIMIT) begin
      tick();
      n++;
    end
    check_flag(idle, "unit never became idle before start");
    start = 1'b1;
    op    = o;
    tick();
    start = 1'b0;
    op    = vctr_op_t'(~o);  // Opcode must already be latched
  endtask

  // Loads A then B, then offers extra junk words that must be dropped
  task automatic load_vectors(input int extra);
    int n;
    n = 0;
    while (!ready && n < 10) begin
      tick();
      n++;
    end
    check_flag(ready, "ready did not rise after start");
    data_in_en = 1'b1;
    for (int i = 0; i < VL; i++) begin
      data_in = vec_a[i];
      tick();
    end
    for (int i = 0; i < VL; i++) begin
      data_in = vec_b[i];
      tick();
    end
    for (int i = 0; i < extra; i++) begin
      data_in = DW'($random(seed));
      tick();
    end
    data_in_en = 1'b0;
  endtask

  task automatic wait_done();
    int n;
    n = 0;
    while (!done && n < DONE_LIMIT) begin
      tick();
      n++;
    end
    check_flag(done, "done did not rise after the operation phase");
  endtask

  task automatic drain_and_check(input int max_gap);
    int gap;
    int n;
    for (int i = 0; i < VL; i++) begin
      check_flag(done, $sformatf("done low before result %0d was read", i));
      check_flag(!idle, $sformatf("idle high before result %0d was read", i));
      check_value($sformatf("data_out[%0d]", i), expected[i], data_out);
      data_out_en = 1'b1;
      tick();
      data_out_en = 1'b0;
      gap = int'($unsigned($random(seed)) % (max_gap + 1));
      repeat (gap) tick();
    end
    n = 0;
    while (!idle && n < 4) begin
      tick();
      n++;
    end
    check_flag(idle && !done, "unit did not return to idle after the last result");
  endtask

  task automatic run_job(input vctr_op_t o, input int max_gap);
    start_job(o);
    load_vectors(0);
    wait_done();
    compute_expected(o);
    drain_and_check(max_gap);
  endtask

  task automatic check_reset_and_start();
    check_flag(idle, "idle low after reset");
    check_flag(!ready, "ready high after reset");
    check_flag(!done, "done high after reset");
    fill_random();
    start_job(OP_XOR);
    check_flag(ready, "ready low one cycle after start");
    check_flag(!idle, "idle high one cycle after start");
    load_vectors(0);
    wait_done();
    compute_expected(OP_XOR);
    drain_and_check(0);
  endtask

  task automatic run_add_vectors();
    for (int i = 0; i < VL; i++) begin
      vec_a[i] = DW'(16'hF000 + i * 16'h0123);  // Every sum but the first overflows
      vec_b[i] = DW'(16'h2000 + i * 16'h0ABC);
    end
    vec_a[0] = 16'h0005;
    vec_b[0] = 16'h0007;
    run_job(OP_ADD, 0);
  endtask

  task automatic run_other_ops();
    fill_random();
    run_job(OP_SUB, 0);
    fill_random();
    run_job(OP_AND, 0);
    fill_random();
    run_job(OP_XOR, 0);
  endtask

  task automatic ignore_stray_input();
    fill_random();
    data_in_en = 1'b1;
    repeat (3) begin
      data_in = DW'($random(seed));  // Junk while idle
      tick();
      check_flag(!ready, "ready rose without start");
    end
    data_in_en = 1'b0;
    start_job(OP_SUB);
    load_vectors(6);  // Junk runs on into the operation phase
    wait_done();
    compute_expected(OP_SUB);
    drain_and_check(0);
  endtask

  task automatic hold_output();
    fill_random();
    start_job(OP_ADD);
    load_vectors(0);
    wait_done();
    compute_expected(OP_ADD);
    repeat (20) begin
      tick();
      check_flag(done, "done fell while results were held");
      check_value("data_out held", expected[0], data_out);
    end
    drain_and_check(3);
  endtask

  task automatic run_back_to_back();
    fill_random();
    run_job(OP_AND, 1);
    fill_random();
    run_job(OP_SUB, 2);
  endtask

  initial begin
    rst_n       = 1'b0;
    start       = 1'b0;
    op          = OP_ADD;
    data_in_en  = 1'b0;
    data_in     = '0;
    data_out_en = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    tick();
    check_reset_and_start();
    run_add_vectors();
    run_other_ops();
    ignore_stray_input();
    hold_output();
    run_back_to_back();
    $display("Summary: %0d errors", errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
rtl/vctr_pkg.sv
rtl/hsid_fifo.sv
rtl/vctr_alu.sv
rtl/vctr_fifo_full.sv
rtl/vctr_unit_top.sv
tests/tb_vctr_unit.sv

/* Makefile */
# Verilator simulation of the vector unit testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_vctr_unit
FILE_LIST ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST OK$$" $(LOG) || (echo "Simulation failed, see $(LOG)" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
